// File: hdl/mips_decode_config.svh
`ifndef MIPS_DECODE_CONFIG_SVH
`define MIPS_DECODE_CONFIG_SVH

// machine address width
`define M_WIDTH 32

// physical register specifier width
`define LG_PRF_ENTRIES 6

// pattern history table index width
`define LG_PHT_SZ 10

// credits toward rename
`define DECODE_CREDITS 4
`define LG_DECODE_CREDITS 3

`define REG_LINK 31

`endif

// File: hdl/decode_pkg.sv
`default_nettype none
`include "mips_decode_config.svh"

package decode_pkg;

	typedef struct packed
	{
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rtype_t;

	typedef struct packed
	{
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm16;
	} itype_t;

	typedef struct packed
	{
		logic [5:0] opcode;
		logic [25:0] index26;
	} jtype_t;

	// one fetched word, read in all three formats
	typedef union packed
	{
		rtype_t r;
		itype_t i;
		jtype_t j;
	} insn_word_t;

	typedef enum logic [5:0]
	{
		SLL, SRL, SRA, SLLV, SRLV, SRAV,
		ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU, MOV,
		JR, JALR, BLTZ, BGEZ, BLTZL, BGEZL, BGEZAL, BAL,
		J, JAL, BEQ, BNE, BLEZ, BGTZ, BEQL, BNEL, BLEZL, BGTZL,
		ADDIU, MOVI, SLTI, SLTIU, ANDI, ORI, XORI, LUI,
		LB, LH, LW, LBU, LHU, SB, SH, SW,
		NOP, II
	} uop_op_t;

	typedef enum logic [2:0] {SRC_NONE, SRC_RS, SRC_RT, SRC_SHAMT, SRC_LINK} src_sel_t;
	typedef enum logic [1:0] {DST_NONE, DST_RD, DST_RT, DST_LINK} dst_sel_t;
	typedef enum logic [1:0] {IMM_ZERO, IMM_16, IMM_INDEX26, IMM_PRED_TARGET} imm_sel_t;

	typedef struct packed
	{
		uop_op_t op;
		uop_op_t op_zero; // used when dst is r0
		src_sel_t src_a_sel;
		src_sel_t src_b_sel;
		dst_sel_t dst_sel;
		imm_sel_t imm_sel;
		logic is_br;
		logic is_mem;
		logic is_store;
		logic has_delay_slot;
		logic has_nullifying_delay_slot;
		logic use_pred;
	} decode_ctrl_t;

	typedef struct packed
	{
		insn_word_t insn;
		logic [`M_WIDTH-1:0] pc;
		logic pred;
		logic [`LG_PHT_SZ-1:0] pht_idx;
		logic [`M_WIDTH-1:0] pred_target;
	} fetch_bundle_t;

	typedef struct packed
	{
		uop_op_t op;
		logic [`LG_PRF_ENTRIES-1:0] src_a;
		logic src_a_valid;
		logic [`LG_PRF_ENTRIES-1:0] src_b;
		logic src_b_valid;
		logic [`LG_PRF_ENTRIES-1:0] dst;
		logic dst_valid;
		logic [15:0] imm;
		logic [`M_WIDTH-17:0] jmp_imm;
		logic [`M_WIDTH-1:0] pc;
		logic br_pred;
		logic [`LG_PHT_SZ-1:0] pht_idx;
		logic is_br;
		logic is_mem;
		logic is_store;
		logic has_delay_slot;
		logic has_nullifying_delay_slot;
	} uop_t;

endpackage

`default_nettype wire

// File: hdl/decode_ctrl.sv
`default_nettype none

module decode_ctrl
(
	input wire decode_pkg::insn_word_t insn,
	input wire dst_zero,
	output decode_pkg::decode_ctrl_t ctrl,
	output decode_pkg::uop_op_t op
);

	decode_pkg::decode_ctrl_t c;
	logic rs_zero;

	assign rs_zero = (insn.r.rs == 5'd0);

	always_comb
	begin
		c.op = decode_pkg::II;
		c.op_zero = decode_pkg::NOP;
		c.src_a_sel = decode_pkg::SRC_NONE;
		c.src_b_sel = decode_pkg::SRC_NONE;
		c.dst_sel = decode_pkg::DST_NONE;
		c.imm_sel = decode_pkg::IMM_ZERO;
		c.is_br = 1'b0;
		c.is_mem = 1'b0;
		c.is_store = 1'b0;
		c.has_delay_slot = 1'b0;
		c.has_nullifying_delay_slot = 1'b0;
		c.use_pred = 1'b0;
		case (insn.r.opcode)
			6'd0:
			begin
				c.dst_sel = decode_pkg::DST_RD;
				c.src_a_sel = decode_pkg::SRC_RT;
				c.src_b_sel = decode_pkg::SRC_RS;
				case (insn.r.funct)
					6'd0: c.op = decode_pkg::SLL;
					6'd2: c.op = decode_pkg::SRL;
					6'd3: c.op = decode_pkg::SRA;
					6'd4: c.op = decode_pkg::SLLV;
					6'd6: c.op = decode_pkg::SRLV;
					6'd7: c.op = decode_pkg::SRAV;
					6'd33: c.op = decode_pkg::ADDU;
					6'd36: c.op = decode_pkg::AND;
					6'd38: c.op = decode_pkg::XOR;
					6'd39: c.op = decode_pkg::NOR;
					6'd42: c.op = decode_pkg::SLT;
					6'd43: c.op = decode_pkg::SLTU;
					6'd35: c.op = decode_pkg::SUBU;
					6'd37: c.op = rs_zero ? decode_pkg::MOV : decode_pkg::OR;
					6'd8, 6'd9:
					begin
						c.op = (insn.r.funct == 6'd9) ? decode_pkg::JALR : decode_pkg::JR;
						c.op_zero = decode_pkg::JR; // jalr to r0 is a plain jr
						c.src_a_sel = decode_pkg::SRC_RS;
						c.src_b_sel = decode_pkg::SRC_NONE;
						c.imm_sel = decode_pkg::IMM_PRED_TARGET;
						c.is_br = 1'b1;
						c.has_delay_slot = 1'b1;
					end
					6'd15, 6'd52: c.op = decode_pkg::NOP; // sync, teq
					default: c.op = decode_pkg::II;
				endcase
				if (insn.r.funct inside {6'd0, 6'd2, 6'd3})
					c.src_b_sel = decode_pkg::SRC_SHAMT;
				if (insn.r.funct == 6'd35)
				begin
					c.src_a_sel = decode_pkg::SRC_RS; // subu keeps rs first
					c.src_b_sel = decode_pkg::SRC_RT;
				end
				if (insn.r.funct == 6'd37 && rs_zero)
					c.src_b_sel = decode_pkg::SRC_NONE;
				if (insn.r.funct == 6'd8)
					c.dst_sel = decode_pkg::DST_NONE;
				if (c.op == decode_pkg::NOP)
				begin
					c.src_a_sel = decode_pkg::SRC_NONE;
					c.src_b_sel = decode_pkg::SRC_NONE;
					c.dst_sel = decode_pkg::DST_NONE;
				end
			end
			6'd1: // regimm
			begin
				c.src_a_sel = decode_pkg::SRC_RS;
				c.imm_sel = decode_pkg::IMM_16;
				c.is_br = 1'b1;
				c.has_delay_slot = 1'b1;
				c.use_pred = 1'b1;
				c.has_nullifying_delay_slot = (insn.i.rt == 5'd2) || (insn.i.rt == 5'd3);
				case (insn.i.rt)
					5'd0: c.op = decode_pkg::BLTZ;
					5'd1: c.op = decode_pkg::BGEZ;
					5'd2: c.op = decode_pkg::BLTZL;
					5'd3: c.op = decode_pkg::BGEZL;
					5'd17:
					begin
						c.op = rs_zero ? decode_pkg::BAL : decode_pkg::BGEZAL;
						c.src_a_sel = rs_zero ? decode_pkg::SRC_NONE : decode_pkg::SRC_RS;
						c.src_b_sel = rs_zero ? decode_pkg::SRC_NONE : decode_pkg::SRC_LINK;
						c.dst_sel = decode_pkg::DST_LINK;
					end
					default: c.op = decode_pkg::II;
				endcase
			end
			6'd2, 6'd3:
			begin
				c.op = insn.j.opcode[0] ? decode_pkg::JAL : decode_pkg::J;
				c.dst_sel = insn.j.opcode[0] ? decode_pkg::DST_LINK : decode_pkg::DST_NONE;
				c.imm_sel = decode_pkg::IMM_INDEX26;
				c.is_br = 1'b1;
				c.has_delay_slot = 1'b1;
			end
			6'd4, 6'd5, 6'd6, 6'd7, 6'd20, 6'd21, 6'd22, 6'd23:
			begin
				case (insn.i.opcode)
					6'd4: c.op = decode_pkg::BEQ;
					6'd5: c.op = decode_pkg::BNE;
					6'd6: c.op = decode_pkg::BLEZ;
					6'd7: c.op = decode_pkg::BGTZ;
					6'd20: c.op = decode_pkg::BEQL;
					6'd21: c.op = decode_pkg::BNEL;
					6'd22: c.op = decode_pkg::BLEZL;
					default: c.op = decode_pkg::BGTZL;
				endcase
				c.src_a_sel = decode_pkg::SRC_RS;
				c.src_b_sel = insn.i.opcode[1] ? decode_pkg::SRC_NONE : decode_pkg::SRC_RT;
				c.imm_sel = decode_pkg::IMM_16;
				c.is_br = 1'b1;
				c.has_delay_slot = 1'b1;
				c.has_nullifying_delay_slot = insn.i.opcode[4]; // likely forms
				c.use_pred = 1'b1;
			end
			6'd9, 6'd10, 6'd11, 6'd12, 6'd13, 6'd14, 6'd15:
			begin
				case (insn.i.opcode)
					6'd9: c.op = rs_zero ? decode_pkg::MOVI : decode_pkg::ADDIU;
					6'd10: c.op = decode_pkg::SLTI;
					6'd11: c.op = decode_pkg::SLTIU;
					6'd12: c.op = decode_pkg::ANDI;
					6'd13: c.op = decode_pkg::ORI;
					6'd14: c.op = decode_pkg::XORI;
					default: c.op = decode_pkg::LUI;
				endcase
				c.src_a_sel = (c.op == decode_pkg::MOVI || c.op == decode_pkg::LUI) ?
					decode_pkg::SRC_NONE : decode_pkg::SRC_RS;
				c.dst_sel = decode_pkg::DST_RT;
				c.imm_sel = decode_pkg::IMM_16;
			end
			6'd32, 6'd33, 6'd35, 6'd36, 6'd37, 6'd48: // loads, ll as lw
			begin
				case (insn.i.opcode)
					6'd32: c.op = decode_pkg::LB;
					6'd33: c.op = decode_pkg::LH;
					6'd36: c.op = decode_pkg::LBU;
					6'd37: c.op = decode_pkg::LHU;
					default: c.op = decode_pkg::LW;
				endcase
				c.src_a_sel = decode_pkg::SRC_RS;
				c.dst_sel = decode_pkg::DST_RT;
				c.imm_sel = decode_pkg::IMM_16;
				c.is_mem = 1'b1;
			end
			6'd40, 6'd41, 6'd43:
			begin
				case (insn.i.opcode)
					6'd40: c.op = decode_pkg::SB;
					6'd41: c.op = decode_pkg::SH;
					default: c.op = decode_pkg::SW;
				endcase
				c.src_a_sel = decode_pkg::SRC_RS;
				c.src_b_sel = decode_pkg::SRC_RT;
				c.imm_sel = decode_pkg::IMM_16;
				c.is_mem = 1'b1;
				c.is_store = 1'b1;
			end
			6'd51: c.op = decode_pkg::NOP; // pref
			default: c.op = decode_pkg::II;
		endcase
		// unknown encodings carry nothing
		if (c.op == decode_pkg::II)
		begin
			c.src_a_sel = decode_pkg::SRC_NONE;
			c.src_b_sel = decode_pkg::SRC_NONE;
			c.dst_sel = decode_pkg::DST_NONE;
			c.imm_sel = decode_pkg::IMM_ZERO;
			c.is_br = 1'b0;
			c.is_mem = 1'b0;
			c.is_store = 1'b0;
			c.has_delay_slot = 1'b0;
			c.has_nullifying_delay_slot = 1'b0;
			c.use_pred = 1'b0;
		end
	end

	assign ctrl = c;
	assign op = dst_zero ? c.op_zero : c.op;

endmodule

`default_nettype wire

// File: hdl/operand_select.sv
`default_nettype none
`include "mips_decode_config.svh"

module operand_select
(
	input wire decode_pkg::insn_word_t insn,
	input wire decode_pkg::decode_ctrl_t ctrl,
	output logic [`LG_PRF_ENTRIES-1:0] src_a,
	output logic src_a_valid,
	output logic [`LG_PRF_ENTRIES-1:0] src_b,
	output logic src_b_valid,
	output logic [`LG_PRF_ENTRIES-1:0] dst,
	output logic dst_valid,
	output logic dst_zero
);

	localparam int ZP = `LG_PRF_ENTRIES - 5;

	function automatic logic [`LG_PRF_ENTRIES-1:0] pick_src(input decode_pkg::src_sel_t sel,
		input decode_pkg::insn_word_t w);
		case (sel)
			decode_pkg::SRC_RS: pick_src = {{ZP{1'b0}}, w.r.rs};
			decode_pkg::SRC_RT: pick_src = {{ZP{1'b0}}, w.r.rt};
			decode_pkg::SRC_SHAMT: pick_src = {{ZP{1'b0}}, w.r.shamt};
			decode_pkg::SRC_LINK: pick_src = `LG_PRF_ENTRIES'(`REG_LINK);
			default: pick_src = '0;
		endcase
	endfunction

	assign src_a = pick_src(ctrl.src_a_sel, insn);
	assign src_b = pick_src(ctrl.src_b_sel, insn);
	assign src_a_valid = (ctrl.src_a_sel != decode_pkg::SRC_NONE);
	assign src_b_valid = (ctrl.src_b_sel != decode_pkg::SRC_NONE);

	always_comb
	begin
		case (ctrl.dst_sel)
			decode_pkg::DST_RD: dst = {{ZP{1'b0}}, insn.r.rd};
			decode_pkg::DST_RT: dst = {{ZP{1'b0}}, insn.r.rt};
			decode_pkg::DST_LINK: dst = `LG_PRF_ENTRIES'(`REG_LINK);
			default: dst = '0;
		endcase
	end

	// no destination is not a zero destination
	assign dst_zero = (ctrl.dst_sel != decode_pkg::DST_NONE) && (dst == '0);
	assign dst_valid = (ctrl.dst_sel != decode_pkg::DST_NONE) && !dst_zero;

endmodule

`default_nettype wire

// File: hdl/imm_gen.sv
`default_nettype none
`include "mips_decode_config.svh"

module imm_gen
(
	input wire decode_pkg::insn_word_t insn,
	input wire [`M_WIDTH-1:0] pred_target,
	input wire decode_pkg::decode_ctrl_t ctrl,
	output logic [15:0] imm,
	output logic [`M_WIDTH-17:0] jmp_imm
);

	always_comb
	begin
		case (ctrl.imm_sel)
			decode_pkg::IMM_16:
			begin
				imm = insn.i.imm16;
				jmp_imm = '0;
			end
			decode_pkg::IMM_INDEX26:
			begin
				imm = insn.j.index26[15:0];
				jmp_imm = {{(`M_WIDTH-26){1'b0}}, insn.j.index26[25:16]};
			end
			decode_pkg::IMM_PRED_TARGET: // jr, jalr
			begin
				imm = pred_target[15:0];
				jmp_imm = pred_target[`M_WIDTH-1:16];
			end
			default:
			begin
				imm = '0;
				jmp_imm = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/uop_credit_reg.sv
`default_nettype none
`include "mips_decode_config.svh"

module uop_credit_reg
(
	input wire clk,
	input wire rst,
	input wire fetch_valid,
	input wire decode_pkg::fetch_bundle_t fetch,
	input wire decode_pkg::uop_op_t op,
	input wire decode_pkg::decode_ctrl_t ctrl,
	input wire [`LG_PRF_ENTRIES-1:0] src_a,
	input wire src_a_valid,
	input wire [`LG_PRF_ENTRIES-1:0] src_b,
	input wire src_b_valid,
	input wire [`LG_PRF_ENTRIES-1:0] dst,
	input wire dst_valid,
	input wire [15:0] imm,
	input wire [`M_WIDTH-17:0] jmp_imm,
	input wire credit_return,
	output logic fetch_ready,
	output logic uop_valid,
	output decode_pkg::uop_t uop
);

	logic [`LG_DECODE_CREDITS-1:0] credits;
	logic accept;
	decode_pkg::uop_t next_uop;

	assign fetch_ready = (credits != '0);
	assign accept = fetch_valid && fetch_ready;

	always_comb
	begin
		next_uop.op = op;
		next_uop.src_a = src_a;
		next_uop.src_a_valid = src_a_valid;
		next_uop.src_b = src_b;
		next_uop.src_b_valid = src_b_valid;
		next_uop.dst = dst;
		next_uop.dst_valid = dst_valid;
		next_uop.imm = imm;
		next_uop.jmp_imm = jmp_imm;
		next_uop.pc = fetch.pc;
		next_uop.br_pred = ctrl.use_pred ? fetch.pred : (op == decode_pkg::JAL);
		next_uop.pht_idx = fetch.pht_idx;
		next_uop.is_br = ctrl.is_br;
		next_uop.is_mem = ctrl.is_mem;
		next_uop.is_store = ctrl.is_store;
		next_uop.has_delay_slot = ctrl.has_delay_slot;
		next_uop.has_nullifying_delay_slot = ctrl.has_nullifying_delay_slot;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			credits <= `LG_DECODE_CREDITS'(`DECODE_CREDITS);
			uop_valid <= 1'b0;
		end
		else
		begin
			// accept and return together cancel out
			credits <= credits - {{(`LG_DECODE_CREDITS-1){1'b0}}, accept}
				+ {{(`LG_DECODE_CREDITS-1){1'b0}}, credit_return};
			uop_valid <= accept;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			uop <= next_uop;
	end

endmodule

`default_nettype wire

// File: hdl/mips_decode_stage.sv
`default_nettype none
`include "mips_decode_config.svh"

module mips_decode_stage
(
	input wire clk,
	input wire rst,
	input wire fetch_valid,
	input wire decode_pkg::fetch_bundle_t fetch,
	output logic fetch_ready,
	input wire credit_return,
	output logic uop_valid,
	output decode_pkg::uop_t uop
);

	decode_pkg::decode_ctrl_t ctrl;
	decode_pkg::uop_op_t op;
	logic dst_zero;
	logic [`LG_PRF_ENTRIES-1:0] src_a;
	logic [`LG_PRF_ENTRIES-1:0] src_b;
	logic [`LG_PRF_ENTRIES-1:0] dst;
	logic src_a_valid;
	logic src_b_valid;
	logic dst_valid;
	logic [15:0] imm;
	logic [`M_WIDTH-17:0] jmp_imm;

	decode_ctrl u_ctrl
	(
		.insn(fetch.insn),
		.dst_zero(dst_zero),
		.ctrl(ctrl),
		.op(op)
	);

	operand_select u_operands
	(
		.insn(fetch.insn),
		.ctrl(ctrl),
		.src_a(src_a),
		.src_a_valid(src_a_valid),
		.src_b(src_b),
		.src_b_valid(src_b_valid),
		.dst(dst),
		.dst_valid(dst_valid),
		.dst_zero(dst_zero)
	);

	imm_gen u_imm
	(
		.insn(fetch.insn),
		.pred_target(fetch.pred_target),
		.ctrl(ctrl),
		.imm(imm),
		.jmp_imm(jmp_imm)
	);

	uop_credit_reg u_out
	(
		.clk(clk),
		.rst(rst),
		.fetch_valid(fetch_valid),
		.fetch(fetch),
		.op(op),
		.ctrl(ctrl),
		.src_a(src_a),
		.src_a_valid(src_a_valid),
		.src_b(src_b),
		.src_b_valid(src_b_valid),
		.dst(dst),
		.dst_valid(dst_valid),
		.imm(imm),
		.jmp_imm(jmp_imm),
		.credit_return(credit_return),
		.fetch_ready(fetch_ready),
		.uop_valid(uop_valid),
		.uop(uop)
	);

endmodule

`default_nettype wire

// File: testbench/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// expected micro-op for one fetch bundle from the ISA fields
function automatic decode_pkg::uop_t decode_ref(input decode_pkg::fetch_bundle_t f);
	decode_pkg::uop_t u;
	logic [31:0] w;
	logic [5:0] opc;
	logic [5:0] fn;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] rd;
	logic [4:0] sh;
	logic [4:0] a;
	logic [4:0] b;
	logic [4:0] wreg;
	logic av;
	logic bv;
	logic wr;
	logic cond; // branch that follows the prediction
	logic [1:0] imk; // 0 none, 1 imm16, 2 jump index, 3 predicted target
	w = f.insn;
	opc = w[31:26];
	rs = w[25:21];
	rt = w[20:16];
	rd = w[15:11];
	sh = w[10:6];
	fn = w[5:0];
	u = '0;
	u.op = decode_pkg::II;
	a = 5'd0;
	b = 5'd0;
	wreg = 5'd0;
	av = 1'b0;
	bv = 1'b0;
	wr = 1'b0;
	cond = 1'b0;
	imk = 2'd0;
	if (opc == 6'd0)
	begin
		a = rt;
		b = rs;
		av = 1'b1;
		bv = 1'b1;
		wr = 1'b1;
		wreg = rd;
		case (fn)
			6'd0: u.op = decode_pkg::SLL;
			6'd2: u.op = decode_pkg::SRL;
			6'd3: u.op = decode_pkg::SRA;
			6'd4: u.op = decode_pkg::SLLV;
			6'd6: u.op = decode_pkg::SRLV;
			6'd7: u.op = decode_pkg::SRAV;
			6'd33: u.op = decode_pkg::ADDU;
			6'd35: u.op = decode_pkg::SUBU;
			6'd36: u.op = decode_pkg::AND;
			6'd37: u.op = (rs == 5'd0) ? decode_pkg::MOV : decode_pkg::OR;
			6'd38: u.op = decode_pkg::XOR;
			6'd39: u.op = decode_pkg::NOR;
			6'd42: u.op = decode_pkg::SLT;
			6'd43: u.op = decode_pkg::SLTU;
			6'd8: u.op = decode_pkg::JR;
			6'd9: u.op = decode_pkg::JALR;
			6'd15, 6'd52: u.op = decode_pkg::NOP;
			default: u.op = decode_pkg::II;
		endcase
		if (fn == 6'd0 || fn == 6'd2 || fn == 6'd3)
			b = sh; // fixed shifts
		if (fn == 6'd35)
		begin
			a = rs;
			b = rt;
		end
		if (u.op == decode_pkg::MOV)
			bv = 1'b0;
		if (fn == 6'd8 || fn == 6'd9)
		begin
			a = rs;
			bv = 1'b0;
			wr = fn[0];
			imk = 2'd3;
			u.is_br = 1'b1;
			u.has_delay_slot = 1'b1;
		end
		if (u.op == decode_pkg::NOP || u.op == decode_pkg::II)
		begin
			av = 1'b0;
			bv = 1'b0;
			wr = 1'b0;
		end
	end
	else if (opc == 6'd1 && rt inside {5'd0, 5'd1, 5'd2, 5'd3, 5'd17})
	begin
		a = rs;
		av = 1'b1;
		imk = 2'd1;
		cond = 1'b1;
		u.is_br = 1'b1;
		u.has_delay_slot = 1'b1;
		u.has_nullifying_delay_slot = rt[1]; // bltzl, bgezl
		case (rt)
			5'd0: u.op = decode_pkg::BLTZ;
			5'd1: u.op = decode_pkg::BGEZ;
			5'd2: u.op = decode_pkg::BLTZL;
			5'd3: u.op = decode_pkg::BGEZL;
			default:
			begin
				u.op = (rs == 5'd0) ? decode_pkg::BAL : decode_pkg::BGEZAL;
				av = (rs != 5'd0);
				bv = (rs != 5'd0);
				b = 5'(`REG_LINK);
				wr = 1'b1;
				wreg = 5'(`REG_LINK);
			end
		endcase
	end
	else if (opc == 6'd2 || opc == 6'd3)
	begin
		u.op = opc[0] ? decode_pkg::JAL : decode_pkg::J;
		wr = opc[0];
		wreg = 5'(`REG_LINK);
		imk = 2'd2;
		u.is_br = 1'b1;
		u.has_delay_slot = 1'b1;
	end
	else if (opc inside {[6'd4:6'd7], [6'd20:6'd23]})
	begin
		case (opc)
			6'd4: u.op = decode_pkg::BEQ;
			6'd5: u.op = decode_pkg::BNE;
			6'd6: u.op = decode_pkg::BLEZ;
			6'd7: u.op = decode_pkg::BGTZ;
			6'd20: u.op = decode_pkg::BEQL;
			6'd21: u.op = decode_pkg::BNEL;
			6'd22: u.op = decode_pkg::BLEZL;
			default: u.op = decode_pkg::BGTZL;
		endcase
		a = rs;
		b = rt;
		av = 1'b1;
		bv = !opc[1]; // blez and bgtz compare against zero
		imk = 2'd1;
		cond = 1'b1;
		u.is_br = 1'b1;
		u.has_delay_slot = 1'b1;
		u.has_nullifying_delay_slot = opc[4];
	end
	else if (opc inside {[6'd9:6'd15]})
	begin
		case (opc)
			6'd9: u.op = (rs == 5'd0) ? decode_pkg::MOVI : decode_pkg::ADDIU;
			6'd10: u.op = decode_pkg::SLTI;
			6'd11: u.op = decode_pkg::SLTIU;
			6'd12: u.op = decode_pkg::ANDI;
			6'd13: u.op = decode_pkg::ORI;
			6'd14: u.op = decode_pkg::XORI;
			default: u.op = decode_pkg::LUI;
		endcase
		a = rs;
		av = !(u.op == decode_pkg::MOVI || u.op == decode_pkg::LUI);
		wr = 1'b1;
		wreg = rt;
		imk = 2'd1;
	end
	else if (opc inside {6'd32, 6'd33, 6'd35, 6'd36, 6'd37, 6'd48})
	begin
		case (opc)
			6'd32: u.op = decode_pkg::LB;
			6'd33: u.op = decode_pkg::LH;
			6'd36: u.op = decode_pkg::LBU;
			6'd37: u.op = decode_pkg::LHU;
			default: u.op = decode_pkg::LW; // lw and ll
		endcase
		a = rs;
		av = 1'b1;
		wr = 1'b1;
		wreg = rt;
		imk = 2'd1;
		u.is_mem = 1'b1;
	end
	else if (opc inside {6'd40, 6'd41, 6'd43})
	begin
		case (opc)
			6'd40: u.op = decode_pkg::SB;
			6'd41: u.op = decode_pkg::SH;
			default: u.op = decode_pkg::SW;
		endcase
		a = rs;
		b = rt;
		av = 1'b1;
		bv = 1'b1;
		imk = 2'd1;
		u.is_mem = 1'b1;
		u.is_store = 1'b1;
	end
	else if (opc == 6'd51)
		u.op = decode_pkg::NOP; // pref

	// a write to r0 does nothing but jalr to r0 still jumps
	if (wr && wreg == 5'd0)
		u.op = (u.op == decode_pkg::JALR) ? decode_pkg::JR : decode_pkg::NOP;
	u.src_a = av ? `LG_PRF_ENTRIES'(a) : '0;
	u.src_a_valid = av;
	u.src_b = bv ? `LG_PRF_ENTRIES'(b) : '0;
	u.src_b_valid = bv;
	u.dst = wr ? `LG_PRF_ENTRIES'(wreg) : '0;
	u.dst_valid = wr && (wreg != 5'd0);
	case (imk)
		2'd1: u.imm = w[15:0];
		2'd2:
		begin
			u.imm = w[15:0];
			u.jmp_imm = (`M_WIDTH-16)'(w[25:16]);
		end
		2'd3:
		begin
			u.imm = f.pred_target[15:0];
			u.jmp_imm = f.pred_target[`M_WIDTH-1:16];
		end
		default: u.imm = 16'd0;
	endcase
	u.pc = f.pc;
	u.pht_idx = f.pht_idx;
	u.br_pred = cond ? f.pred : (u.op == decode_pkg::JAL);
	return u;
endfunction

`endif

// File: testbench/tb_mips_decode_stage.sv
`default_nettype none
`include "mips_decode_config.svh"

module tb_mips_decode_stage;

	localparam int SEED = 32'h133418c9;
	localparam int N_RTYPE = 200;
	localparam int N_ITYPE = 200;
	localparam int N_BRANCH = 200;
	localparam int N_BAD = 100;
	localparam int N_FLOW = 300;
	localparam int N_TOTAL = N_RTYPE + N_ITYPE + N_BRANCH + N_BAD + N_FLOW + `DECODE_CREDITS + 20;
	localparam int MARGIN = 12; // cycles per instruction incl. gaps and slow returns
	localparam int WATCHDOG_CYCLES = N_TOTAL * MARGIN + 200;

	localparam logic [5:0] R_FUNCTS [18] = '{6'd0, 6'd2, 6'd3, 6'd4, 6'd6, 6'd7, 6'd33,
		6'd35, 6'd36, 6'd37, 6'd38, 6'd39, 6'd42, 6'd43, 6'd8, 6'd9, 6'd15, 6'd52};
	localparam logic [5:0] I_OPS [17] = '{6'd9, 6'd10, 6'd11, 6'd12, 6'd13, 6'd14, 6'd15,
		6'd32, 6'd33, 6'd35, 6'd36, 6'd37, 6'd48, 6'd40, 6'd41, 6'd43, 6'd51};
	localparam logic [4:0] REGIMM_RT [5] = '{5'd0, 5'd1, 5'd2, 5'd3, 5'd17};
	localparam logic [5:0] BR_OPS [10] = '{6'd2, 6'd3, 6'd4, 6'd5, 6'd6, 6'd7,
		6'd20, 6'd21, 6'd22, 6'd23};

	logic clk;
	logic rst;
	logic fetch_valid;
	decode_pkg::fetch_bundle_t fetch;
	logic fetch_ready;
	logic credit_return;
	logic uop_valid;
	decode_pkg::uop_t uop;

	integer seed = SEED;
	integer ret_seed = ~SEED; // consumer gets its own stream
	int errors = 0;
	int checks = 0;
	int n_uops = 0;
	int n_tests = 0;
	int owed; // credits the consumer still holds
	logic [1:0] ret_mode; // 0 return at once, 1 hold, 2 random
	logic give;
	logic [31:0] rr;
	decode_pkg::uop_t exp_q[$];

	`include "decode_model.svh"

	mips_decode_stage dut_i
	(
		.clk(clk),
		.rst(rst),
		.fetch_valid(fetch_valid),
		.fetch(fetch),
		.fetch_ready(fetch_ready),
		.credit_return(credit_return),
		.uop_valid(uop_valid),
		.uop(uop)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, the decode stage stopped making progress",
			WATCHDOG_CYCLES);
		$display("Errors found");
		$finish;
	end

	task automatic compare_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %s: got %0h, expected %0h", name, got, exp);
		end
	endtask

	task automatic compare_uop(input decode_pkg::uop_t e);
		compare_value("op", 64'(uop.op), 64'(e.op));
		compare_value("src_a", 64'(uop.src_a), 64'(e.src_a));
		compare_value("src_a_valid", 64'(uop.src_a_valid), 64'(e.src_a_valid));
		compare_value("src_b", 64'(uop.src_b), 64'(e.src_b));
		compare_value("src_b_valid", 64'(uop.src_b_valid), 64'(e.src_b_valid));
		compare_value("dst", 64'(uop.dst), 64'(e.dst));
		compare_value("dst_valid", 64'(uop.dst_valid), 64'(e.dst_valid));
		compare_value("imm", 64'(uop.imm), 64'(e.imm));
		compare_value("jmp_imm", 64'(uop.jmp_imm), 64'(e.jmp_imm));
		compare_value("pc", 64'(uop.pc), 64'(e.pc));
		compare_value("br_pred", 64'(uop.br_pred), 64'(e.br_pred));
		compare_value("pht_idx", 64'(uop.pht_idx), 64'(e.pht_idx));
		compare_value("is_br", 64'(uop.is_br), 64'(e.is_br));
		compare_value("is_mem", 64'(uop.is_mem), 64'(e.is_mem));
		compare_value("is_store", 64'(uop.is_store), 64'(e.is_store));
		compare_value("has_delay_slot", 64'(uop.has_delay_slot), 64'(e.has_delay_slot));
		compare_value("has_nullifying_delay_slot", 64'(uop.has_nullifying_delay_slot),
			64'(e.has_nullifying_delay_slot));
	endtask

	function automatic logic [4:0] rand_reg();
		logic [31:0] r;
		r = $random(seed);
		rand_reg = (r[9:8] == 2'd0) ? 5'd0 : r[4:0]; // r0 a quarter of the time
	endfunction

	function automatic decode_pkg::fetch_bundle_t rand_bundle(input logic [31:0] word);
		decode_pkg::fetch_bundle_t b;
		logic [31:0] r;
		b.insn = word;
		r = $random(seed);
		b.pc = {r[31:2], 2'b00};
		r = $random(seed);
		b.pred = r[0];
		b.pht_idx = r[`LG_PHT_SZ:1];
		r = $random(seed);
		b.pred_target = {r[31:2], 2'b00};
		return b;
	endfunction

	function automatic logic [31:0] rtype_word();
		logic [31:0] s;
		s = $random(seed);
		return {6'd0, rand_reg(), rand_reg(), rand_reg(), s[10:6], R_FUNCTS[s % 32'd18]};
	endfunction

	function automatic logic [31:0] itype_word();
		logic [31:0] s;
		s = $random(seed);
		return {I_OPS[s[31:16] % 16'd17], rand_reg(), rand_reg(), s[15:0]};
	endfunction

	function automatic logic [31:0] branch_word();
		logic [31:0] r;
		logic [31:0] s;
		int sel;
		r = $random(seed);
		s = $random(seed);
		sel = int'(r % 32'd17);
		if (sel < 5)
			return {6'd1, rand_reg(), REGIMM_RT[sel], s[15:0]};
		else if (sel < 15)
			return {BR_OPS[sel-5], rand_reg(), rand_reg(), s[15:0]};
		else
			return {6'd0, rand_reg(), s[20:16], rand_reg(), 5'd0, (sel == 15) ? 6'd8 : 6'd9};
	endfunction

	// unused opcode, funct or regimm rt
	function automatic logic [31:0] bad_word();
		logic [31:0] r;
		logic [31:0] s;
		r = $random(seed);
		s = $random(seed);
		if (r[1:0] == 2'd2)
		begin
			while (s[5:0] inside {6'd0, 6'd2, 6'd3, 6'd4, 6'd6, 6'd7, 6'd8, 6'd9, 6'd15,
				6'd33, 6'd35, 6'd36, 6'd37, 6'd38, 6'd39, 6'd42, 6'd43, 6'd52})
				s = $random(seed);
			return {6'd0, s[25:0]};
		end
		else if (r[1:0] == 2'd3)
		begin
			while (s[20:16] inside {5'd0, 5'd1, 5'd2, 5'd3, 5'd17})
				s = $random(seed);
			return {6'd1, s[25:0]};
		end
		while (s[31:26] inside {[6'd0:6'd7], [6'd9:6'd15], [6'd20:6'd23], 6'd32, 6'd33,
			6'd35, 6'd36, 6'd37, 6'd40, 6'd41, 6'd43, 6'd48, 6'd51})
			s = $random(seed);
		return s;
	endfunction

	task automatic send(input logic [31:0] word);
		fetch <= rand_bundle(word);
		fetch_valid <= 1'b1;
		@(posedge clk);
		while (!fetch_ready)
			@(posedge clk);
	endtask

	task automatic pause(input int n);
		fetch_valid <= 1'b0;
		repeat (n) @(posedge clk);
	endtask

	task automatic drain();
		fetch_valid <= 1'b0;
		@(negedge clk);
		while (exp_q.size() != 0 || owed != 0 || credit_return)
			@(negedge clk);
		@(posedge clk);
	endtask

	task automatic end_test(input string name, input int err_before);
		drain();
		n_tests++;
		$display("test %-10s %s, %0d mismatches", name,
			(errors == err_before) ? "passed" : "FAILED", errors - err_before);
	endtask

	// rename side retires, records accepts and hands credits back
	initial
	begin
		credit_return <= 1'b0;
		owed = 0;
		forever
		begin
			@(posedge clk);
			if (rst)
			begin
				credit_return <= 1'b0;
				owed = 0;
			end
			else
			begin
				if (uop_valid)
				begin
					n_uops++;
					owed++;
					if (exp_q.size() == 0)
					begin
						errors++;
						$display("a micro-op came out with no accepted instruction waiting for it");
					end
					else
						compare_uop(exp_q.pop_front());
				end
				if (fetch_valid && fetch_ready)
					exp_q.push_back(decode_ref(fetch));
				rr = $random(ret_seed);
				give = (owed > 0) && (ret_mode == 2'd0 || (ret_mode == 2'd2 && rr[0]));
				credit_return <= give;
				if (give)
					owed--;
			end
		end
	end

	initial
	begin
		int err0;
		int sent;
		int base;
		logic [31:0] r;
		rst <= 1'b1;
		fetch_valid <= 1'b0;
		fetch <= '0;
		ret_mode <= 2'd0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		err0 = errors;
		compare_value("uop_valid", 64'(uop_valid), 64'd0);
		compare_value("fetch_ready", 64'(fetch_ready), 64'd1);
		@(posedge clk);
		end_test("reset", err0);

		err0 = errors;
		for (int i = 0; i < N_RTYPE; i++)
			send(rtype_word());
		end_test("rtype", err0);

		err0 = errors;
		for (int i = 0; i < N_ITYPE; i++)
			send(itype_word());
		end_test("itype", err0);

		err0 = errors;
		for (int i = 0; i < N_BRANCH; i++)
			send(branch_word());
		end_test("branch", err0);

		err0 = errors;
		for (int i = 0; i < N_BAD; i++)
			send(bad_word());
		end_test("illegal", err0);

		// consumer keeps every credit
		err0 = errors;
		ret_mode <= 2'd1;
		base = n_uops;
		sent = 0;
		fetch <= rand_bundle(itype_word());
		fetch_valid <= 1'b1;
		for (int i = 0; i < `DECODE_CREDITS + 8; i++)
		begin
			@(posedge clk);
			if (fetch_ready)
			begin
				sent++;
				fetch <= rand_bundle(itype_word());
			end
		end
		fetch_valid <= 1'b0;
		ret_mode <= 2'd0;
		@(negedge clk);
		compare_value("accepted while held", 64'(sent), 64'(`DECODE_CREDITS));
		compare_value("uops while held", 64'(n_uops - base), 64'(`DECODE_CREDITS));
		compare_value("fetch_ready while held", 64'(fetch_ready), 64'd0);
		@(posedge clk);
		end_test("backpress", err0);

		err0 = errors;
		ret_mode <= 2'd2;
		base = n_uops;
		for (int i = 0; i < N_FLOW; i++)
		begin
			r = $random(seed);
			case (r[1:0])
				2'd0: send(rtype_word());
				2'd1: send(itype_word());
				2'd2: send(branch_word());
				default: send(bad_word());
			endcase
			if (r[4:2] == 3'd0)
				pause(int'(r[6:5]) + 1);
		end
		ret_mode <= 2'd0;
		drain();
		compare_value("uops in random flow", 64'(n_uops - base), 64'(N_FLOW));
		end_test("flow", err0);

		$display("%0d tests, %0d checks, %0d mismatches", n_tests, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: mips_decode_stage.f
+incdir+hdl
+incdir+testbench
hdl/decode_pkg.sv
hdl/decode_ctrl.sv
hdl/operand_select.sv
hdl/imm_gen.sv
hdl/uop_credit_reg.sv
hdl/mips_decode_stage.sv
testbench/tb_mips_decode_stage.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_mips_decode_stage \
	-f mips_decode_stage.f --Mdir obj_dir &&
./obj_dir/Vtb_mips_decode_stage | tee /dev/stderr | grep -qx "No errors" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }
